// ==== include/mem_iq_cfg.svh ====
`ifndef MEM_IQ_CFG_SVH
`define MEM_IQ_CFG_SVH

// enqueue lanes and issue lanes per cycle
`define MEM_ISSUE_WIDTH 2

// physical integer registers
`define IPHYREG_NUM 64

// reorder buffer entries, smaller index is older
`define ROB_SIZE 32

// writeback ports, these confirm a source
`define WB_PORT_NUM 4

// speculative wakeups from other issue queues
`define EXT_WAKEUP_NUM 2

// store issue notifications per cycle
`define STORE_ISSUE_WIDTH 1

`endif

// ==== verilog/mem_iq_pkg.sv ====
`default_nettype none

`include "mem_iq_cfg.svh"

package mem_iq_pkg;

    typedef logic [$clog2(`IPHYREG_NUM)-1:0] ipr_idx_t;
    typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

    // memory micro-op as carried through the queue
    typedef struct packed {
        rob_idx_t rob_idx;
        // store this op has to wait for
        rob_idx_t dep_rob_idx;
        ipr_idx_t iprs_idx;
        ipr_idx_t iprd_idx;
        // loads write a register
        logic     rd_wen;
        logic     is_store;
    } mem_exe_info_t;

    // one wakeup port, writeback or speculative
    typedef struct packed {
        logic     vld;
        ipr_idx_t idx;
    } wakeup_t;

    // true when any writeback port carries this register
    function automatic logic wb_hit(input ipr_idx_t idx, input wakeup_t wb [`WB_PORT_NUM]);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `WB_PORT_NUM; p++) begin
            if (wb[p].vld && (wb[p].idx == idx)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/age_schedule.sv ====
`default_nettype none
`timescale 1ns/10ps

module age_schedule #(
    parameter int WIDTH = 8,
    parameter int OUTS = 2
) (
    input  wire [WIDTH-1:0]            i_vld,
    input  wire mem_iq_pkg::rob_idx_t  i_ages [WIDTH],
    output logic [OUTS-1:0]            o_vld,
    output logic [$clog2(WIDTH)-1:0]   o_sel_idx [OUTS]
);

    import mem_iq_pkg::*;

    localparam int IDX_W = $clog2(WIDTH);
    localparam int NPAD = 1 << IDX_W;

    // one compare tree per output, winners are masked for the next pass
    always_comb begin
        logic [WIDTH-1:0] remain;
        logic [NPAD-1:0]  node_vld;
        rob_idx_t         node_age [NPAD];
        logic [IDX_W-1:0] node_idx [NPAD];

        remain = i_vld;
        for (int k = 0; k < OUTS; k++) begin
            // leaves, padding slots never win
            for (int n = 0; n < NPAD; n++) begin
                if (n < WIDTH) begin
                    node_vld[n] = remain[n];
                    node_age[n] = i_ages[n];
                end else begin
                    node_vld[n] = 1'b0;
                    node_age[n] = '0;
                end
                node_idx[n] = IDX_W'(n);
            end

            // pairwise reduce in place, on a tie the lower slot wins
            for (int lvl = 0; lvl < IDX_W; lvl++) begin
                for (int n = 0; n < (NPAD >> (lvl + 1)); n++) begin
                    if (node_vld[2*n+1] &&
                        (!node_vld[2*n] || (node_age[2*n+1] < node_age[2*n]))) begin
                        node_vld[n] = 1'b1;
                        node_age[n] = node_age[2*n+1];
                        node_idx[n] = node_idx[2*n+1];
                    end else begin
                        node_vld[n] = node_vld[2*n];
                        node_age[n] = node_age[2*n];
                        node_idx[n] = node_idx[2*n];
                    end
                end
            end

            o_vld[k] = node_vld[0];
            o_sel_idx[k] = node_idx[0];
            if (node_vld[0]) begin
                remain[node_idx[0]] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_issue_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mem_iq_cfg.svh"

module mem_issue_queue #(
    parameter int DEPTH = 8
) (
    input  wire                             clk,
    input  wire                             rst,
    // enqueue
    output logic                            o_can_enq,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_req,
    input  wire mem_iq_pkg::mem_exe_info_t  i_enq_info [`MEM_ISSUE_WIDTH],
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_src_rdy,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_memdep_rdy,
    // issue
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_fu_busy,
    output logic [`MEM_ISSUE_WIDTH-1:0]     o_can_issue,
    output logic [$clog2(DEPTH)-1:0]        o_issue_idx [`MEM_ISSUE_WIDTH],
    output mem_iq_pkg::mem_exe_info_t       o_issue_info [`MEM_ISSUE_WIDTH],
    output logic [`MEM_ISSUE_WIDTH-1:0]     o_issue_src_confirmed,
    // feedback from register read
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_finish_vec,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_replay_vec,
    input  wire [$clog2(DEPTH)-1:0]         i_feedback_idx [`MEM_ISSUE_WIDTH],
    // wakeup
    input  wire mem_iq_pkg::wakeup_t        i_wb [`WB_PORT_NUM],
    input  wire mem_iq_pkg::wakeup_t        i_ext_wakeup [`EXT_WAKEUP_NUM],
    output mem_iq_pkg::wakeup_t             o_export_wakeup [`MEM_ISSUE_WIDTH],
    // memory dependence release
    input  wire [`STORE_ISSUE_WIDTH-1:0]    i_store_issue,
    input  wire mem_iq_pkg::rob_idx_t       i_store_rob_idx [`STORE_ISSUE_WIDTH]
);

    import mem_iq_pkg::*;

    localparam int W = `MEM_ISSUE_WIDTH;
    localparam int IDX_W = $clog2(DEPTH);
    // internal wakeups come first, then the external ones
    localparam int SPEC_NUM = W + `EXT_WAKEUP_NUM;

    function automatic logic spec_hit(input ipr_idx_t idx, input wakeup_t src [SPEC_NUM]);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < SPEC_NUM; p++) begin
            if (src[p].vld && (src[p].idx == idx)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic store_hit(input rob_idx_t dep);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < `STORE_ISSUE_WIDTH; s++) begin
            if (i_store_issue[s] && (i_store_rob_idx[s] == dep)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // entry status
    logic [DEPTH-1:0] ent_vld;
    logic [DEPTH-1:0] ent_issued;
    logic [DEPTH-1:0] ent_memdep_rdy;
    logic [DEPTH-1:0] ent_src_rdy;
    logic [DEPTH-1:0] ent_spec_rdy;
    mem_exe_info_t    ent_info [DEPTH];

    logic [DEPTH-1:0] nxt_memdep_rdy;
    logic [DEPTH-1:0] nxt_src_rdy;
    logic [DEPTH-1:0] nxt_spec_rdy;
    logic [DEPTH-1:0] entry_ready;
    rob_idx_t         ages [DEPTH];

    logic [W-1:0]     enq_found;
    logic [W-1:0]     enq_fire;
    logic [IDX_W-1:0] enq_slot [W];
    logic [W-1:0]     enq_src_w;
    logic [W-1:0]     enq_spec_w;
    logic [W-1:0]     enq_memdep_w;

    logic [W-1:0]     sel_vld;
    logic [IDX_W-1:0] sel_idx [W];
    logic [W-1:0]     issue_go;
    logic [W-1:0]     sel_vld_q;
    logic [IDX_W-1:0] sel_idx_q [W];
    wakeup_t          spec_src [SPEC_NUM];

    // lowest free slots, lane k gets the k-th one
    always_comb begin
        logic [DEPTH-1:0] taken;
        taken = '0;
        for (int k = 0; k < W; k++) begin
            enq_found[k] = 1'b0;
            enq_slot[k] = '0;
            for (int e = DEPTH - 1; e >= 0; e--) begin
                if (!ent_vld[e] && !taken[e]) begin
                    enq_found[k] = 1'b1;
                    enq_slot[k] = IDX_W'(e);
                end
            end
            if (enq_found[k]) begin
                taken[enq_slot[k]] = 1'b1;
            end
        end
    end

    assign o_can_enq = &enq_found;
    assign enq_fire = i_enq_req & enq_found;

    always_comb begin
        for (int e = 0; e < DEPTH; e++) begin
            entry_ready[e] = ent_vld[e] && !ent_issued[e] && ent_memdep_rdy[e] &&
                             (ent_src_rdy[e] || ent_spec_rdy[e]);
            ages[e] = ent_info[e].rob_idx;
        end
    end

    age_schedule #(
        .WIDTH (DEPTH),
        .OUTS  (W)
    ) u_age_schedule (
        .i_vld     (entry_ready),
        .i_ages    (ages),
        .o_vld     (sel_vld),
        .o_sel_idx (sel_idx)
    );

    // a held lane does not issue, so it wakes nobody
    assign issue_go = sel_vld & ~i_fu_busy;

    always_comb begin
        for (int k = 0; k < W; k++) begin
            spec_src[k].vld = issue_go[k] && ent_info[sel_idx[k]].rd_wen;
            spec_src[k].idx = ent_info[sel_idx[k]].iprd_idx;
            o_export_wakeup[k] = spec_src[k];
        end
        for (int x = 0; x < `EXT_WAKEUP_NUM; x++) begin
            spec_src[W+x] = i_ext_wakeup[x];
        end
    end

    // next readiness for resident entries and for incoming ops
    always_comb begin
        for (int e = 0; e < DEPTH; e++) begin
            nxt_src_rdy[e] = ent_src_rdy[e] | wb_hit(ent_info[e].iprs_idx, i_wb);
            nxt_spec_rdy[e] = ent_spec_rdy[e] | nxt_src_rdy[e] |
                              spec_hit(ent_info[e].iprs_idx, spec_src);
            nxt_memdep_rdy[e] = ent_memdep_rdy[e] | store_hit(ent_info[e].dep_rob_idx);
        end
        for (int k = 0; k < W; k++) begin
            enq_src_w[k] = i_enq_src_rdy[k] | wb_hit(i_enq_info[k].iprs_idx, i_wb);
            enq_spec_w[k] = enq_src_w[k] | spec_hit(i_enq_info[k].iprs_idx, spec_src);
            enq_memdep_w[k] = i_enq_memdep_rdy[k] | store_hit(i_enq_info[k].dep_rob_idx);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vld <= '0;
            ent_issued <= '0;
            ent_memdep_rdy <= '0;
            ent_src_rdy <= '0;
            ent_spec_rdy <= '0;
            sel_vld_q <= '0;
        end else begin
            ent_memdep_rdy <= nxt_memdep_rdy;
            ent_src_rdy <= nxt_src_rdy;
            ent_spec_rdy <= nxt_spec_rdy;
            for (int k = 0; k < W; k++) begin
                if (enq_fire[k]) begin
                    ent_vld[enq_slot[k]] <= 1'b1;
                    ent_issued[enq_slot[k]] <= 1'b0;
                    ent_memdep_rdy[enq_slot[k]] <= enq_memdep_w[k];
                    ent_src_rdy[enq_slot[k]] <= enq_src_w[k];
                    ent_spec_rdy[enq_slot[k]] <= enq_spec_w[k];
                end
                if (!i_fu_busy[k]) begin
                    sel_vld_q[k] <= sel_vld[k];
                    if (sel_vld[k]) begin
                        ent_issued[sel_idx[k]] <= 1'b1;
                    end
                end
                // replay falls back to what writeback has confirmed
                if (i_finish_vec[k]) begin
                    ent_vld[i_feedback_idx[k]] <= 1'b0;
                end else if (i_replay_vec[k]) begin
                    ent_issued[i_feedback_idx[k]] <= 1'b0;
                    ent_spec_rdy[i_feedback_idx[k]] <= nxt_src_rdy[i_feedback_idx[k]];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < W; k++) begin
            if (enq_fire[k]) begin
                ent_info[enq_slot[k]] <= i_enq_info[k];
            end
            if (!i_fu_busy[k]) begin
                sel_idx_q[k] <= sel_idx[k];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < W; k++) begin
            o_issue_idx[k] = sel_idx_q[k];
            o_issue_info[k] = ent_info[sel_idx_q[k]];
            o_issue_src_confirmed[k] = ent_src_rdy[sel_idx_q[k]];
        end
    end

    assign o_can_issue = sel_vld_q;

endmodule

`default_nettype wire

// ==== verilog/mem_issue_feedback.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mem_iq_cfg.svh"

module mem_issue_feedback #(
    parameter int DEPTH = 8
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_can_issue,
    input  wire [$clog2(DEPTH)-1:0]         i_issue_idx [`MEM_ISSUE_WIDTH],
    input  wire mem_iq_pkg::mem_exe_info_t  i_issue_info [`MEM_ISSUE_WIDTH],
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_issue_src_confirmed,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_fu_busy,
    input  wire mem_iq_pkg::wakeup_t        i_wb [`WB_PORT_NUM],
    output logic [`MEM_ISSUE_WIDTH-1:0]     o_finish_vec,
    output logic [`MEM_ISSUE_WIDTH-1:0]     o_replay_vec,
    output logic [$clog2(DEPTH)-1:0]        o_feedback_idx [`MEM_ISSUE_WIDTH],
    output logic [`MEM_ISSUE_WIDTH-1:0]     o_exe_vld,
    output mem_iq_pkg::mem_exe_info_t       o_exe_info [`MEM_ISSUE_WIDTH]
);

    import mem_iq_pkg::*;

    localparam int W = `MEM_ISSUE_WIDTH;
    localparam int IDX_W = $clog2(DEPTH);

    // register read cycle
    logic [W-1:0]     cap_vld;
    logic [W-1:0]     cap_confirmed;
    logic [IDX_W-1:0] cap_idx [W];
    mem_exe_info_t    cap_info [W];
    logic [W-1:0]     read_ok;
    logic [W-1:0]     finish_q;
    logic [W-1:0]     replay_q;

    always_comb begin
        for (int k = 0; k < W; k++) begin
            read_ok[k] = cap_confirmed[k] | wb_hit(cap_info[k].iprs_idx, i_wb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cap_vld <= '0;
            finish_q <= '0;
            replay_q <= '0;
        end else begin
            cap_vld <= i_can_issue & ~i_fu_busy;
            finish_q <= cap_vld & read_ok;
            replay_q <= cap_vld & ~read_ok;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < W; k++) begin
            if (i_can_issue[k] && !i_fu_busy[k]) begin
                cap_idx[k] <= i_issue_idx[k];
                cap_info[k] <= i_issue_info[k];
                // a writeback on the capture edge counts as confirmed
                cap_confirmed[k] <= i_issue_src_confirmed[k] |
                                    wb_hit(i_issue_info[k].iprs_idx, i_wb);
            end
            if (cap_vld[k]) begin
                o_feedback_idx[k] <= cap_idx[k];
                o_exe_info[k] <= cap_info[k];
            end
        end
    end

    assign o_finish_vec = finish_q;
    assign o_replay_vec = replay_q;
    assign o_exe_vld = finish_q;

endmodule

`default_nettype wire

// ==== verilog/mem_issue_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mem_iq_cfg.svh"

module mem_issue_stage (
    input  wire                             clk,
    input  wire                             rst,
    // dispatch side
    output logic                            o_can_enq,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_req,
    input  wire mem_iq_pkg::mem_exe_info_t  i_enq_info [`MEM_ISSUE_WIDTH],
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_src_rdy,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_memdep_rdy,
    input  wire [`MEM_ISSUE_WIDTH-1:0]      i_fu_busy,
    // wakeup and store release
    input  wire mem_iq_pkg::wakeup_t        i_wb [`WB_PORT_NUM],
    input  wire mem_iq_pkg::wakeup_t        i_ext_wakeup [`EXT_WAKEUP_NUM],
    input  wire [`STORE_ISSUE_WIDTH-1:0]    i_store_issue,
    input  wire mem_iq_pkg::rob_idx_t       i_store_rob_idx [`STORE_ISSUE_WIDTH],
    output mem_iq_pkg::wakeup_t             o_export_wakeup [`MEM_ISSUE_WIDTH],
    // toward the address unit
    output logic [`MEM_ISSUE_WIDTH-1:0]     o_exe_vld,
    output mem_iq_pkg::mem_exe_info_t       o_exe_info [`MEM_ISSUE_WIDTH]
);

    import mem_iq_pkg::*;

    localparam int W = `MEM_ISSUE_WIDTH;
    localparam int IQ_DEPTH = 8;
    localparam int IDX_W = $clog2(IQ_DEPTH);

    logic [W-1:0]     can_issue;
    logic [IDX_W-1:0] issue_idx [W];
    mem_exe_info_t    issue_info [W];
    logic [W-1:0]     issue_src_confirmed;
    logic [W-1:0]     finish_vec;
    logic [W-1:0]     replay_vec;
    logic [IDX_W-1:0] feedback_idx [W];

    mem_issue_queue #(
        .DEPTH (IQ_DEPTH)
    ) u_queue (
        .clk                   (clk),
        .rst                   (rst),
        .o_can_enq             (o_can_enq),
        .i_enq_req             (i_enq_req),
        .i_enq_info            (i_enq_info),
        .i_enq_src_rdy         (i_enq_src_rdy),
        .i_enq_memdep_rdy      (i_enq_memdep_rdy),
        .i_fu_busy             (i_fu_busy),
        .o_can_issue           (can_issue),
        .o_issue_idx           (issue_idx),
        .o_issue_info          (issue_info),
        .o_issue_src_confirmed (issue_src_confirmed),
        .i_finish_vec          (finish_vec),
        .i_replay_vec          (replay_vec),
        .i_feedback_idx        (feedback_idx),
        .i_wb                  (i_wb),
        .i_ext_wakeup          (i_ext_wakeup),
        .o_export_wakeup       (o_export_wakeup),
        .i_store_issue         (i_store_issue),
        .i_store_rob_idx       (i_store_rob_idx)
    );

    mem_issue_feedback #(
        .DEPTH (IQ_DEPTH)
    ) u_feedback (
        .clk                   (clk),
        .rst                   (rst),
        .i_can_issue           (can_issue),
        .i_issue_idx           (issue_idx),
        .i_issue_info          (issue_info),
        .i_issue_src_confirmed (issue_src_confirmed),
        .i_fu_busy             (i_fu_busy),
        .i_wb                  (i_wb),
        .o_finish_vec          (finish_vec),
        .o_replay_vec          (replay_vec),
        .o_feedback_idx        (feedback_idx),
        .o_exe_vld             (o_exe_vld),
        .o_exe_info            (o_exe_info)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        o_rst = 1'b1;
    end

    always #20 o_clk = ~o_clk;

    // reset held for five rising edges
    initial begin
        repeat (5) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/mem_iq_chk.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mem_iq_cfg.svh"

module mem_iq_chk (
    input wire                             clk,
    input wire                             rst,
    input wire [`MEM_ISSUE_WIDTH-1:0]      i_enq_req,
    input wire                             o_can_enq,
    input wire [`MEM_ISSUE_WIDTH-1:0]      o_exe_vld,
    input wire mem_iq_pkg::mem_exe_info_t  o_exe_info [`MEM_ISSUE_WIDTH]
);

    import mem_iq_pkg::*;

    int fail_cnt = 0;

    // rob indices that already left toward the address unit
    logic [`ROB_SIZE-1:0] seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen <= '0;
        end else begin
            for (int k = 0; k < `MEM_ISSUE_WIDTH; k++) begin
                if (o_exe_vld[k]) begin
                    seen[o_exe_info[k].rob_idx] <= 1'b1;
                end
            end
        end
    end

    a_enq_allowed: assert property (@(posedge clk) disable iff (rst)
        (|i_enq_req) |-> o_can_enq)
    else begin
        $error("enqueue while queue cannot accept");
        fail_cnt++;
    end

    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !(|o_exe_vld))
    else begin
        $error("exe valid raised right after reset");
        fail_cnt++;
    end

    for (genvar k = 0; k < `MEM_ISSUE_WIDTH; k++) begin : g_lane
        a_no_repeat: assert property (@(posedge clk) disable iff (rst)
            o_exe_vld[k] |-> !seen[o_exe_info[k].rob_idx])
        else begin
            $error("rob index finished twice on lane %0d", k);
            fail_cnt++;
        end
    end

    // both lanes in one cycle never carry the same op
    a_lanes_differ: assert property (@(posedge clk) disable iff (rst)
        (&o_exe_vld) |-> (o_exe_info[0].rob_idx != o_exe_info[1].rob_idx))
    else begin
        $error("same rob index on both lanes");
        fail_cnt++;
    end

endmodule

bind mem_issue_stage mem_iq_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .i_enq_req  (i_enq_req),
    .o_can_enq  (o_can_enq),
    .o_exe_vld  (o_exe_vld),
    .o_exe_info (o_exe_info)
);

`default_nettype wire

// ==== verif/tb_mem_issue.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mem_iq_cfg.svh"

module tb_mem_issue;

    import mem_iq_pkg::*;

    localparam int W = `MEM_ISSUE_WIDTH;

    typedef struct packed {
        logic [7:0]    op;
        logic [31:0]   arg;
        logic          lane;
        logic          src_rdy;
        logic          memdep_rdy;
        mem_exe_info_t info;
    } stim_cmd_t;

    logic clk;
    logic rst;

    logic                          can_enq;
    logic [W-1:0]                  enq_req;
    mem_exe_info_t                 enq_info [W];
    logic [W-1:0]                  enq_src_rdy;
    logic [W-1:0]                  enq_memdep_rdy;
    logic [W-1:0]                  fu_busy;
    wakeup_t                       wb [`WB_PORT_NUM];
    wakeup_t                       ext_wakeup [`EXT_WAKEUP_NUM];
    logic [`STORE_ISSUE_WIDTH-1:0] store_issue;
    rob_idx_t                      store_rob_idx [`STORE_ISSUE_WIDTH];
    wakeup_t                       export_wakeup [W];
    logic [W-1:0]                  exe_vld;
    mem_exe_info_t                 exe_info [W];

    stim_cmd_t              cmds [$];
    rob_idx_t               exp_order [$];
    rob_idx_t               fin_order [$];
    mem_exe_info_t          exp_info [`ROB_SIZE];
    logic [`ROB_SIZE-1:0]   done;
    logic [`IPHYREG_NUM-1:0] exported;
    int                     errors = 0;
    int                     cycles = 0;
    int                     limit = 0;

    tb_clkgen u_clkgen (
        .o_clk (clk),
        .o_rst (rst)
    );

    mem_issue_stage DUT (
        .clk              (clk),
        .rst              (rst),
        .o_can_enq        (can_enq),
        .i_enq_req        (enq_req),
        .i_enq_info       (enq_info),
        .i_enq_src_rdy    (enq_src_rdy),
        .i_enq_memdep_rdy (enq_memdep_rdy),
        .i_fu_busy        (fu_busy),
        .i_wb             (wb),
        .i_ext_wakeup     (ext_wakeup),
        .i_store_issue    (store_issue),
        .i_store_rob_idx  (store_rob_idx),
        .o_export_wakeup  (export_wakeup),
        .o_exe_vld        (exe_vld),
        .o_exe_info       (exe_info)
    );

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic record_finish(input mem_exe_info_t info);
        compare(32'(info), 32'(exp_info[info.rob_idx]), "finished op info");
        compare(32'(done[info.rob_idx]), 32'd0, "op finished twice");
        done[info.rob_idx] = 1'b1;
        fin_order.push_back(info.rob_idx);
    endtask

    task automatic clear_inputs();
        enq_req = '0;
        enq_src_rdy = '0;
        enq_memdep_rdy = '0;
        store_issue = '0;
        for (int k = 0; k < W; k++) begin
            enq_info[k] = '0;
        end
        for (int p = 0; p < `WB_PORT_NUM; p++) begin
            wb[p] = '0;
        end
        for (int x = 0; x < `EXT_WAKEUP_NUM; x++) begin
            ext_wakeup[x] = '0;
        end
        for (int s = 0; s < `STORE_ISSUE_WIDTH; s++) begin
            store_rob_idx[s] = '0;
        end
    endtask

    task automatic load_stim();
        int        fd;
        int        n;
        int        lane;
        int        src;
        int        mem;
        int        rob;
        int        dep;
        int        iprs;
        int        iprd;
        int        wen;
        int        st;
        int        arg;
        string     tok;
        string     rest;
        stim_cmd_t c;
        fd = $fopen("verif/mem_iq_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open stimulus file verif/mem_iq_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %s", tok);
            if (n != 1) begin
                break;
            end
            c = '0;
            c.op = tok[0];
            if (tok[0] == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "E") begin
                n = $fscanf(fd, " %d %d %d %d %d %d %d %d %d",
                            lane, src, mem, rob, dep, iprs, iprd, wen, st);
                c.lane = lane[0];
                c.src_rdy = src[0];
                c.memdep_rdy = mem[0];
                c.info.rob_idx = rob_idx_t'(rob);
                c.info.dep_rob_idx = rob_idx_t'(dep);
                c.info.iprs_idx = ipr_idx_t'(iprs);
                c.info.iprd_idx = ipr_idx_t'(iprd);
                c.info.rd_wen = wen[0];
                c.info.is_store = st[0];
                cmds.push_back(c);
            end else if (tok == "R") begin
                cmds.push_back(c);
            end else if (tok == "F") begin
                n = $fscanf(fd, " %d", arg);
                exp_order.push_back(rob_idx_t'(arg));
            end else begin
                n = $fscanf(fd, " %d", arg);
                c.arg = arg;
                cmds.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_cmd(input stim_cmd_t c);
        case (c.op)
            "E": begin
                while (!can_enq) begin
                    @(negedge clk);
                end
                enq_req[c.lane] = 1'b1;
                enq_info[c.lane] = c.info;
                enq_src_rdy[c.lane] = c.src_rdy;
                enq_memdep_rdy[c.lane] = c.memdep_rdy;
                exp_info[c.info.rob_idx] = c.info;
                @(negedge clk);
                clear_inputs();
            end
            "W": begin
                wb[0] = {1'b1, ipr_idx_t'(c.arg)};
                @(negedge clk);
                clear_inputs();
            end
            "X": begin
                ext_wakeup[0] = {1'b1, ipr_idx_t'(c.arg)};
                @(negedge clk);
                clear_inputs();
            end
            "S": begin
                store_issue[0] = 1'b1;
                store_rob_idx[0] = rob_idx_t'(c.arg);
                @(negedge clk);
                clear_inputs();
            end
            "B": fu_busy = W'(c.arg);
            "I": repeat (c.arg) @(negedge clk);
            "R": repeat (1 + ($urandom % 4)) @(negedge clk);
            "D": begin
                while (fin_order.size() < c.arg) begin
                    @(negedge clk);
                end
            end
            "C": compare(32'(can_enq), c.arg, "can_enq level");
            "N": compare(32'(done[c.arg]), 32'd0, "op finished too early");
            "P": compare(32'(exported[c.arg]), 32'd1, "register never exported");
            default: begin
                errors++;
                $display("unknown stimulus command %c", c.op);
            end
        endcase
    endtask

    // outputs are sampled before the edge updates them
    always @(posedge clk) begin
        if (!rst) begin
            for (int k = 0; k < W; k++) begin
                if (export_wakeup[k].vld) begin
                    exported[export_wakeup[k].idx] = 1'b1;
                end
            end
            if ((&exe_vld) && (exe_info[1].rob_idx < exe_info[0].rob_idx)) begin
                record_finish(exe_info[1]);
                record_finish(exe_info[0]);
            end else begin
                for (int k = 0; k < W; k++) begin
                    if (exe_vld[k]) begin
                        record_finish(exe_info[k]);
                    end
                end
            end
        end
    end

    // cycle limit scales with the command count
    always @(posedge clk) begin
        cycles++;
        if ((limit > 0) && (cycles > limit)) begin
            $display("timeout: run did not complete within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int asrt_fails;
        void'($urandom(32'hcf6f));
        fu_busy = '0;
        done = '0;
        exported = '0;
        clear_inputs();
        load_stim();
        limit = cmds.size() * 20;

        wait (!rst);
        @(negedge clk);
        foreach (cmds[i]) begin
            run_cmd(cmds[i]);
        end
        repeat (8) @(negedge clk);

        compare(32'(fin_order.size()), 32'(exp_order.size()), "number of finished ops");
        for (int i = 0; i < exp_order.size(); i++) begin
            if (i < fin_order.size()) begin
                compare(32'(fin_order[i]), 32'(exp_order[i]), "finish order");
            end
        end

        asrt_fails = DUT.u_chk.fail_cnt;
        $display("closing: %0d mismatch errors, %0d assertion failures", errors, asrt_fails);
        if ((errors == 0) && (asrt_fails == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mem_iq_stim.txt ====
# E lane src_rdy memdep_rdy rob dep iprs iprd rd_wen is_store
# W reg, X reg, S rob, B mask, I n, R, D count, C level, N rob, P reg, F rob
# oldest first, queued behind busy lanes
B 3
E 0 1 1 3 0 1 43 1 0
E 1 1 1 1 0 1 41 1 0
E 0 1 1 2 0 1 42 0 1
E 1 1 1 0 0 1 40 1 0
B 0
D 4
# source wakeup by writeback
R
E 0 0 1 4 0 10 44 1 0
E 1 1 1 5 0 1 45 1 0
E 0 1 1 6 0 1 46 0 1
D 6
N 4
I 3
N 4
W 10
D 7
# memory dependence on store 7
R
E 0 1 0 8 7 1 48 1 0
E 1 1 1 9 0 1 49 1 0
D 8
I 4
N 8
S 7
D 9
# speculative wakeup alone replays
E 0 0 1 10 0 20 50 1 0
I 3
X 20
I 10
N 10
W 20
D 10
# back-pressure with seven entries held
B 3
E 0 1 1 11 0 1 51 1 0
E 1 1 1 12 0 1 52 1 0
E 0 1 1 13 0 1 53 0 1
E 1 1 1 14 0 1 54 1 0
E 0 1 1 15 0 1 55 1 0
E 1 1 1 16 0 1 56 0 1
E 0 1 1 17 0 1 57 1 0
C 0
B 2
I 6
B 0
D 17
# internal wakeup from a load
E 0 1 1 18 0 1 30 1 0
E 1 0 1 19 0 30 59 1 0
I 4
P 30
N 19
W 30
D 19
# expected finish order
F 0
F 1
F 2
F 3
F 5
F 6
F 4
F 9
F 8
F 10
F 11
F 12
F 13
F 14
F 15
F 16
F 17
F 18
F 19

// ==== project.f ====
+incdir+include
verilog/mem_iq_pkg.sv
verilog/age_schedule.sv
verilog/mem_issue_queue.sv
verilog/mem_issue_feedback.sv
verilog/mem_issue_stage.sv
verif/tb_clkgen.sv
verif/mem_iq_chk.sv
verif/tb_mem_issue.sv

// ==== Bender.yml ====
package:
  name: mem_issue_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/mem_iq_pkg.sv
      - verilog/age_schedule.sv
      - verilog/mem_issue_queue.sv
      - verilog/mem_issue_feedback.sv
      - verilog/mem_issue_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_clkgen.sv
      - verif/mem_iq_chk.sv
      - verif/tb_mem_issue.sv
